//--- icache_top.f
src/icache_pkg.sv
src/icache_way.sv
src/icache_ctrl.sv
src/way_merge.sv
src/icache_top.sv
tests/icache_mem_model.sv
tests/tb_icache_top.sv

//--- Bender.yml
package:
  name: icache_top

sources:
  - src/icache_pkg.sv
  - src/icache_way.sv
  - src/icache_ctrl.sv
  - src/way_merge.sv
  - src/icache_top.sv
  - target: test
    files:
      - tests/icache_mem_model.sv
      - tests/tb_icache_top.sv

//--- tests/tb_icache_top.sv
`timescale 1ns/1ps

module tb_icache_top import icache_pkg::*;;

    localparam int TIMEOUT = 200;

    // each row holds a fetch address, a flush flag and the expected misses
    // an expected count of -1 is not predicted
    typedef struct packed {
        addr_t addr;
        logic  flush;
        int    exp_miss;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        flush;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    logic        miss;
    refill_req_t refill_req;
    refill_rsp_t refill_rsp;

    stim_t       stim_q[$];
    int          miss_cnt = 0;

    icache_top #(
        .NumWays (4)
    ) DUT (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .flush_i      (flush),
        .fetch_req_i  (fetch_req),
        .fetch_rsp_o  (fetch_rsp),
        .miss_o       (miss),
        .refill_req_o (refill_req),
        .refill_rsp_i (refill_rsp)
    );

    icache_mem_model i_mem (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .refill_req_i (refill_req),
        .refill_rsp_o (refill_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // count miss pulses on the falling edge
    always @(negedge clk) begin
        if (rst_n && miss) begin
            miss_cnt++;
        end
    end

    // ----------------------------------------------------------------------
    // reference model and checks
    // ----------------------------------------------------------------------
    function automatic fetch_t expected_word(input addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input fetch_t got, input fetch_t exp, input addr_t addr);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: word at %h is %h, expected %h",
                                     $time, addr, got, exp));
        end
    endtask

    task automatic check_miss(input int got, input int lo, input int hi, input string what);
        if (got < lo || got > hi) begin
            report_failure(
                $sformatf("Mismatch at %0t: %s counted %0d misses, expected %0d to %0d",
                          $time, what, got, lo, hi));
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("Mismatch at %0t: %s took %0d cycles, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // bus tasks sample and drive 1 ns after the rising edge
    // ----------------------------------------------------------------------
    // cycles counts the edges waited until ready was seen
    task automatic wait_ready(output int cycles);
        cycles = 0;
        while (!fetch_rsp.ready) begin
            if (cycles == TIMEOUT) begin
                report_failure(
                    $sformatf("Timeout: fetch ready stayed low for %0d cycles", TIMEOUT));
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // cycles counts the wait beyond the first cycle after acceptance
    task automatic wait_valid(output int cycles);
        cycles = 0;
        while (!fetch_rsp.valid) begin
            if (cycles == TIMEOUT) begin
                report_failure(
                    $sformatf("Timeout: no fetch response within %0d cycles", TIMEOUT));
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic fetch_one(input addr_t addr, output fetch_t word, output int lat);
        int ready_wait;
        fetch_req.req  = 1'b1;
        fetch_req.addr = addr;
        wait_ready(ready_wait);
        // accepted at this edge
        @(posedge clk);
        #1;
        fetch_req.req = 1'b0;
        wait_valid(lat);
        word = fetch_rsp.data;
    endtask

    // req stays high and each hit answers in the cycle after its acceptance
    task automatic fetch_stream(input addr_t addrs[4]);
        int miss_start;
        int ready_wait;
        miss_start     = miss_cnt;
        fetch_req.req  = 1'b1;
        fetch_req.addr = addrs[0];
        wait_ready(ready_wait);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (!fetch_rsp.valid) begin
                report_failure("no response in the cycle after a back-to-back hit was accepted");
            end
            check_word(fetch_rsp.data, expected_word(addrs[i]), addrs[i]);
            if (i < 3) begin
                if (!fetch_rsp.ready) begin
                    report_failure("fetch ready dropped between back-to-back hits");
                end
                fetch_req.addr = addrs[i+1];
            end else begin
                fetch_req.req = 1'b0;
            end
        end
        check_miss(miss_cnt - miss_start, 0, 0, "back-to-back hits");
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic add_stim(input addr_t addr, input logic flush_en, input int exp_miss);
        stim_q.push_back('{addr: addr, flush: flush_en, exp_miss: exp_miss});
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        fetch_t      word;
        int          lat;
        int          miss_start;
        int          group_miss;
        int          flush_wait;
        logic [31:0] rnd;
        addr_t       addr;

        rst_n      = 1'b0;
        flush      = 1'b0;
        fetch_req  = '0;
        group_miss = 0;
        rnd        = 32'd58;

        // cold miss followed by hits in the same line
        add_stim(32'h0000_0104, 1'b0, 1);
        add_stim(32'h0000_010C, 1'b0, 0);
        add_stim(32'h0000_0100, 1'b0, 0);
        // four lines of set 3 fill the invalid ways
        add_stim(32'h0000_1030, 1'b0, 1);
        add_stim(32'h0000_2034, 1'b0, 1);
        add_stim(32'h0000_3038, 1'b0, 1);
        add_stim(32'h0000_403C, 1'b0, 1);
        add_stim(32'h0000_1034, 1'b0, 0);
        add_stim(32'h0000_2038, 1'b0, 0);
        add_stim(32'h0000_303C, 1'b0, 0);
        add_stim(32'h0000_4030, 1'b0, 0);
        // fifth line evicts a random way
        add_stim(32'h0000_5030, 1'b0, 1);
        add_stim(32'h0000_1030, 1'b0, -1);
        add_stim(32'h0000_2030, 1'b0, -1);
        add_stim(32'h0000_3030, 1'b0, -1);
        add_stim(32'h0000_4030, 1'b0, -1);
        add_stim(32'h0000_5030, 1'b0, -1);
        // flush drops a cached line
        add_stim(32'h0000_0108, 1'b1, 1);
        add_stim(32'h0000_0104, 1'b0, 0);

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // the flush walk after reset visits every set once
        wait_ready(flush_wait);
        check_cycles(flush_wait, int'(NUM_SETS), "flush walk after reset");

        foreach (stim_q[i]) begin
            if (stim_q[i].flush) begin
                pulse_flush();
            end
            miss_start = miss_cnt;
            fetch_one(stim_q[i].addr, word, lat);
            check_word(word, expected_word(stim_q[i].addr), stim_q[i].addr);
            if (stim_q[i].exp_miss >= 0) begin
                check_miss(miss_cnt - miss_start, stim_q[i].exp_miss, stim_q[i].exp_miss,
                           $sformatf("fetch of %h", stim_q[i].addr));
                if (stim_q[i].exp_miss == 0) begin
                    check_cycles(lat, 0,
                                 $sformatf("extra wait of the hit at %h", stim_q[i].addr));
                end
            end else begin
                group_miss += miss_cnt - miss_start;
            end
        end
        // at least the evicted line misses again
        check_miss(group_miss, 1, 5, "re-read of the full set");

        fetch_stream('{32'h0000_0100, 32'h0000_0104, 32'h0000_0108, 32'h0000_010C});

        // random word addresses
        repeat (40) begin
            rnd  = xorshift32(rnd);
            addr = {rnd[31:2], 2'b00};
            fetch_one(addr, word, lat);
            check_word(word, expected_word(addr), addr);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tests/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model import icache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  refill_req_t refill_req_i,
    output refill_rsp_t refill_rsp_o
);

    localparam logic [31:0] SEED = 32'd58;

    // delay generator state
    logic [31:0] rng_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // idle for 0 to 3 cycles
    task automatic wait_gap();
        int gap;
        rng_q = xorshift32(rng_q);
        gap   = int'(rng_q[1:0]);
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // grant, then four beats with gaps, word at A is A xor 5A5A_5A5A
    task automatic serve_line(input addr_t line_addr);
        addr_t beat_addr;
        wait_gap();
        refill_rsp_o.gnt = 1'b1;
        @(posedge clk_i);
        #1;
        refill_rsp_o.gnt = 1'b0;
        for (int b = 0; b < LINE_BEATS; b++) begin
            wait_gap();
            beat_addr           = line_addr + addr_t'(b * (FETCH_W / 8));
            refill_rsp_o.rvalid = 1'b1;
            refill_rsp_o.rlast  = (b == LINE_BEATS - 1);
            refill_rsp_o.data   = beat_addr ^ 32'h5A5A_5A5A;
            @(posedge clk_i);
            #1;
            refill_rsp_o.rvalid = 1'b0;
            refill_rsp_o.rlast  = 1'b0;
        end
    endtask

    // poll the request just after each rising edge
    initial begin
        refill_rsp_o = '0;
        rng_q        = SEED;
        forever begin
            @(posedge clk_i);
            #1;
            if (rst_ni && refill_req_i.valid) begin
                serve_line(refill_req_i.addr);
            end
        end
    end

endmodule

//--- src/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int unsigned NumWays = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_i,
    input  fetch_req_t  fetch_req_i,
    output fetch_rsp_t  fetch_rsp_o,
    output logic        miss_o,
    output refill_req_t refill_req_o,
    input  refill_rsp_t refill_rsp_i
);

    // controller to ways
    logic    [NumWays-1:0] array_req;
    logic    [NumWays-1:0] array_we;
    index_t                index;
    tag_t                  wtag;
    fetch_t                wbeat;
    beat_t                 beat;
    logic                  flush_sets;

    // ways to merge
    way_rd_t [NumWays-1:0] way_rd;
    logic    [NumWays-1:0] way_hit;

    // merge to controller
    logic                  any_hit;
    fetch_t                hit_word;
    logic    [NumWays-1:0] victim;
    logic                  lfsr_step;

    // ----------------------------------------------------------------------
    // controller
    // ----------------------------------------------------------------------
    icache_ctrl #(
        .NumWays (NumWays)
    ) i_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_rsp_o  (fetch_rsp_o),
        .miss_o       (miss_o),
        .refill_req_o (refill_req_o),
        .refill_rsp_i (refill_rsp_i),
        .array_req_o  (array_req),
        .array_we_o   (array_we),
        .index_o      (index),
        .wtag_o       (wtag),
        .wbeat_o      (wbeat),
        .beat_o       (beat),
        .flush_o      (flush_sets),
        .any_hit_i    (any_hit),
        .hit_word_i   (hit_word),
        .victim_i     (victim),
        .lfsr_step_o  (lfsr_step)
    );

    // ----------------------------------------------------------------------
    // ways
    // ----------------------------------------------------------------------
    for (genvar w = 0; w < NumWays; w++) begin : g_way
        icache_way i_way (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (array_req[w]),
            .we_i    (array_we[w]),
            .flush_i (flush_sets),
            .index_i (index),
            .tag_i   (wtag),
            .wbeat_i (wbeat),
            .beat_i  (beat),
            .rd_o    (way_rd[w]),
            .hit_o   (way_hit[w])
        );
    end

    // hit select and victim choice
    way_merge #(
        .NumWays (NumWays)
    ) i_merge (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_i        (way_rd),
        .hit_i       (way_hit),
        .offset_i    (beat),
        .lfsr_step_i (lfsr_step),
        .any_hit_o   (any_hit),
        .hit_word_o  (hit_word),
        .victim_o    (victim)
    );

endmodule

//--- src/way_merge.sv
`timescale 1ns/1ps

module way_merge import icache_pkg::*; #(
    parameter int unsigned NumWays = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  way_rd_t [NumWays-1:0]       rd_i,
    input  logic    [NumWays-1:0]       hit_i,
    input  beat_t                       offset_i,
    input  logic                        lfsr_step_i,
    output logic                        any_hit_o,
    output fetch_t                      hit_word_o,
    output logic    [NumWays-1:0]       victim_o
);

    localparam int unsigned WAY_IDX_W = $clog2(NumWays);

    fetch_t [NumWays-1:0] sel_word;
    logic   [NumWays-1:0] way_valid;
    logic   [7:0]         lfsr_q;
    logic                 all_valid;

    // ----------------------------------------------------------------------
    // hit data
    // ----------------------------------------------------------------------
    for (genvar w = 0; w < NumWays; w++) begin : g_sel
        assign sel_word[w]  = hit_i[w] ? rd_i[w].line[offset_i*FETCH_W +: FETCH_W] : '0;
        assign way_valid[w] = rd_i[w].valid;
    end

    // at most one way hits, so OR is enough
    always_comb begin
        hit_word_o = '0;
        for (int w = 0; w < NumWays; w++) begin
            hit_word_o |= sel_word[w];
        end
    end

    assign any_hit_o = |hit_i;
    assign all_valid = &way_valid;

    // ----------------------------------------------------------------------
    // replacement
    // ----------------------------------------------------------------------
    // lowest invalid way first, random way when the set is full
    always_comb begin
        victim_o = '0;
        if (all_valid) begin
            victim_o[lfsr_q[WAY_IDX_W-1:0]] = 1'b1;
        end else begin
            for (int w = NumWays - 1; w >= 0; w--) begin
                if (!way_valid[w]) begin
                    victim_o = '0;
                    victim_o[w] = 1'b1;
                end
            end
        end
    end

    // 8-bit maximal length LFSR, x^8 + x^6 + x^5 + x^4 + 1
    // only steps when the random choice was used
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= 8'hA5;
        end else if (lfsr_step_i && all_valid) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    // a line lives in at most one way
    hit_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_i)
    ) else $error("more than one way hit");

endmodule

//--- src/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; #(
    parameter int unsigned NumWays = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  fetch_req_t         fetch_req_i,
    output fetch_rsp_t         fetch_rsp_o,
    output logic               miss_o,
    output refill_req_t        refill_req_o,
    input  refill_rsp_t        refill_rsp_i,
    output logic [NumWays-1:0] array_req_o,
    output logic [NumWays-1:0] array_we_o,
    output index_t             index_o,
    output tag_t               wtag_o,
    output fetch_t             wbeat_o,
    output beat_t              beat_o,
    output logic               flush_o,
    input  logic               any_hit_i,
    input  fetch_t             hit_word_i,
    input  logic [NumWays-1:0] victim_i,
    output logic               lfsr_step_o
);

    ctrl_state_e        state_d, state_q;
    addr_t              addr_d, addr_q;
    logic [NumWays-1:0] victim_d, victim_q;
    beat_t              beat_d, beat_q;
    index_t             flush_cnt_d, flush_cnt_q;
    logic               flush_pend_d, flush_pend_q;

    // new request taken this cycle
    logic               accept;
    logic               flush_req;

    // a flush is either arriving now or still waiting
    assign flush_req = flush_i || flush_pend_q;

    // ----------------------------------------------------------------------
    // next state logic
    // ----------------------------------------------------------------------
    always_comb begin
        state_d           = state_q;
        victim_d          = victim_q;
        beat_d            = beat_q;
        flush_cnt_d       = flush_cnt_q;
        flush_pend_d      = flush_pend_q || flush_i;
        accept            = 1'b0;
        fetch_rsp_o.ready = 1'b0;
        fetch_rsp_o.valid = 1'b0;
        miss_o            = 1'b0;
        lfsr_step_o       = 1'b0;
        array_req_o       = '0;
        array_we_o        = '0;
        refill_req_o.valid = 1'b0;
        flush_o           = 1'b0;

        case (state_q)
            // walk all sets and clear their valid bits
            FLUSH: begin
                flush_o     = 1'b1;
                flush_cnt_d = flush_cnt_q + 1'b1;
                if (flush_cnt_q == index_t'(NUM_SETS - 1)) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (flush_req) begin
                    state_d      = FLUSH;
                    flush_pend_d = 1'b0;
                    flush_cnt_d  = '0;
                end else begin
                    fetch_rsp_o.ready = 1'b1;
                    if (fetch_req_i.req) begin
                        accept  = 1'b1;
                        state_d = TAG_CMP;
                    end
                end
            end
            // read data of all ways is on the merge now
            TAG_CMP, TAG_CMP_SAVED: begin
                if (any_hit_i) begin
                    fetch_rsp_o.valid = 1'b1;
                    state_d           = IDLE;
                    // overlap the next lookup unless a flush waits
                    if (!flush_req) begin
                        fetch_rsp_o.ready = 1'b1;
                        if (fetch_req_i.req) begin
                            accept  = 1'b1;
                            state_d = TAG_CMP;
                        end
                    end
                end else begin
                    // count only the first lookup of a request
                    miss_o      = (state_q == TAG_CMP);
                    lfsr_step_o = 1'b1;
                    victim_d    = victim_i;
                    state_d     = REFILL_REQ;
                end
            end
            // hold the burst request until the memory grants it
            REFILL_REQ: begin
                refill_req_o.valid = 1'b1;
                if (refill_rsp_i.gnt) begin
                    beat_d  = '0;
                    state_d = REFILL_DATA;
                end
            end
            // write each beat into the victim way
            REFILL_DATA: begin
                if (refill_rsp_i.rvalid) begin
                    array_req_o = victim_q;
                    array_we_o  = victim_q;
                    beat_d      = beat_q + 1'b1;
                    if (refill_rsp_i.rlast) begin
                        state_d = REDO;
                    end
                end
            end
            // read the refilled set again
            REDO: begin
                array_req_o = '1;
                state_d     = TAG_CMP_SAVED;
            end
            default: state_d = IDLE;
        endcase

        // a new lookup reads all ways
        if (accept) begin
            array_req_o = '1;
        end
    end

    assign addr_d = accept ? fetch_req_i.addr : addr_q;

    // ----------------------------------------------------------------------
    // array side
    // ----------------------------------------------------------------------
    always_comb begin
        if (state_q == FLUSH) begin
            index_o = flush_cnt_q;
        end else if (accept) begin
            index_o = fetch_req_i.addr[OFFSET_W +: INDEX_W];
        end else begin
            index_o = addr_q[OFFSET_W +: INDEX_W];
        end
    end

    // beat number while refilling, word offset for the merge otherwise
    assign beat_o  = (state_q == REFILL_DATA) ? beat_q : addr_q[WORD_LSB +: BEAT_W];
    assign wtag_o  = addr_q[ADDR_W-1 -: TAG_W];
    assign wbeat_o = refill_rsp_i.data;

    assign fetch_rsp_o.data  = hit_word_i;
    assign refill_req_o.addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= FLUSH;
            victim_q     <= '0;
            beat_q       <= '0;
            flush_cnt_q  <= '0;
            flush_pend_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            victim_q     <= victim_d;
            beat_q       <= beat_d;
            flush_cnt_q  <= flush_cnt_d;
            flush_pend_q <= flush_pend_d;
        end
    end

    // saved fetch address
    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
    end

    // refill request held with a stable address until granted
    refill_hold: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        refill_req_o.valid && !refill_rsp_i.gnt
            |=> refill_req_o.valid && $stable(refill_req_o.addr)
    ) else $error("refill request dropped or changed before gnt");

endmodule

//--- src/icache_way.sv
`timescale 1ns/1ps

module icache_way import icache_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    req_i,
    input  logic    we_i,
    input  logic    flush_i,
    input  index_t  index_i,
    input  tag_t    tag_i,
    input  fetch_t  wbeat_i,
    input  beat_t   beat_i,
    output way_rd_t rd_o,
    output logic    hit_o
);

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------
    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];

    // registered read port
    logic                vld_rd_q;
    tag_t                tag_rd_q;
    line_t               line_rd_q;

    // last refill beat completes the line
    logic                last_beat;

    assign last_beat = (beat_i == beat_t'(LINE_BEATS - 1));

    // valid bits, cleared by the flush walk one set per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q[index_i] <= 1'b0;
        end else if (req_i && we_i && last_beat) begin
            valid_q[index_i] <= 1'b1;
        end
    end

    // tag and line arrays
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            // each beat fills one quarter of the line
            line_mem[index_i][beat_i*FETCH_W +: FETCH_W] <= wbeat_i;
            if (last_beat) begin
                tag_mem[index_i] <= tag_i;
            end
        end
    end

    // read valid flag, kept at zero until the first read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_rd_q <= 1'b0;
        end else if (req_i && !we_i) begin
            vld_rd_q <= valid_q[index_i];
        end
    end

    // tag and line read data, one cycle after the request
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            tag_rd_q  <= tag_mem[index_i];
            line_rd_q <= line_mem[index_i];
        end
    end

    assign rd_o.valid = vld_rd_q;
    assign rd_o.tag   = tag_rd_q;
    assign rd_o.line  = line_rd_q;

    // the controller holds the lookup tag on tag_i
    assign hit_o = vld_rd_q && (tag_rd_q == tag_i);

endmodule

//--- src/icache_pkg.sv
package icache_pkg;

    // ----------------------------------------------------------------------
    // cache geometry
    // ----------------------------------------------------------------------
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned FETCH_W    = 32;
    localparam int unsigned LINE_BEATS = 4;
    localparam int unsigned NUM_SETS   = 16;

    // derived widths
    localparam int unsigned LINE_W     = FETCH_W * LINE_BEATS;
    localparam int unsigned OFFSET_W   = $clog2(LINE_W / 8);
    localparam int unsigned WORD_LSB   = $clog2(FETCH_W / 8);
    localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
    localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int unsigned BEAT_W     = $clog2(LINE_BEATS);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [FETCH_W-1:0] fetch_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [BEAT_W-1:0]  beat_t;

    // ----------------------------------------------------------------------
    // port structs
    // ----------------------------------------------------------------------
    // core fetch request
    typedef struct packed {
        logic  req;
        addr_t addr;
    } fetch_req_t;

    // core fetch response, valid is a single cycle pulse
    typedef struct packed {
        logic   ready;
        logic   valid;
        fetch_t data;
    } fetch_rsp_t;

    // line refill request, addr is line aligned
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } refill_req_t;

    // refill response beats
    typedef struct packed {
        logic   gnt;
        logic   rvalid;
        logic   rlast;
        fetch_t data;
    } refill_rsp_t;

    // read-out of one way
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        line_t line;
    } way_rd_t;

    typedef enum logic [2:0] {
        FLUSH,
        IDLE,
        TAG_CMP,
        REFILL_REQ,
        REFILL_DATA,
        REDO,
        TAG_CMP_SAVED
    } ctrl_state_e;

endpackage
